// ==== all.f ====
+incdir+common
common/bht_pkg.sv
bht/bht_way.sv
bht/bht_write_ctl.sv
bht/bht_select.sv
design/bht_top.sv
testbench/tb_bht.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_bht
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_bht.sv ====
`timescale 1ns/1ns
`include "bht_config.svh"

module tb_bht;
	import bht_pkg::*;

	localparam int HALF_PERIOD   = 20;
	localparam int NSETS         = 1 << `BHT_SET_W;
	localparam int RESET_TIMEOUT = 50;
	localparam int RANDOM_CYCLES = 3000;

	logic     CLK = 1'b0;
	logic     arst_n = 1'b0;
	if_req_t  if_req;
	id_req_t  id_req;
	exe_req_t exe_req;
	if_pred_t if_pred;
	exe_res_t exe_res;
	logic     flush;

	// requests staged for the next falling edge
	if_req_t  if_nxt;
	id_req_t  id_nxt;
	exe_req_t exe_nxt;

	////////////////////////////////////////
	// reference table
	////////////////////////////////////////

	logic                  m_valid [NSETS][`BHT_WAYS];
	logic [`BHT_TAG_W-1:0] m_tag [NSETS][`BHT_WAYS];
	logic [`BHT_PC_W-1:0]  m_tgt [NSETS][`BHT_WAYS];
	logic [`BHT_CNT_W-1:0] m_cnt [NSETS][`BHT_WAYS];
	logic [1:0]            m_ptr [NSETS];

	logic [31:0] lfsr_q;

	bht_top uut (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.if_req  (if_req),
		.id_req  (id_req),
		.exe_req (exe_req),
		.if_pred (if_pred),
		.exe_res (exe_res),
		.flush   (flush)
	);

	// 40 ns period
	always #(HALF_PERIOD) CLK = ~CLK;

	// reset held for five cycles and released on a falling edge
	initial
	begin
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		arst_n = 1'b1;
	end

	////////////////////////////////////////
	// random source and stimulus helpers
	////////////////////////////////////////

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic random_bit();
		logic [31:0] r;
		r = take_bits(1);
		return r[0];
	endfunction

	function automatic pc_u pc_of(input logic [`BHT_TAG_W-1:0] tag,
		input logic [`BHT_SET_W-1:0] set);
		pc_u p;
		p.fld.tag = tag;
		p.fld.set = set;
		return p;
	endfunction

	// eight sets with six tags each so sets overflow and evict
	function automatic pc_u pool_pc();
		logic [31:0] set_bits;
		logic [31:0] tag_idx;
		set_bits = take_bits(3);
		tag_idx  = take_bits(3) % 6;
		return pc_of(6'(tag_idx * 13), 4'(set_bits));
	endfunction

	function automatic if_pred_t pred_value(input logic hit, input logic taken,
		input logic [`BHT_PC_W-1:0] pbt);
		if_pred_t p;
		p.hit   = hit;
		p.taken = taken;
		p.pbt   = pbt;
		return p;
	endfunction

	task automatic clear_requests();
		if_nxt  = '0;
		id_nxt  = '0;
		exe_nxt = '0;
	endtask

	// decode sees a branch or a jump when jump is set
	task automatic decode_entry(input pc_u pc, input logic [`BHT_PC_W-1:0] target,
		input logic jump);
		id_nxt.valid    = 1'b1;
		id_nxt.pc       = pc;
		id_nxt.target   = target;
		id_nxt.is_jump  = jump;
		id_nxt.is_btype = !jump;
	endtask

	task automatic resolve_branch(input pc_u pc, input logic [`BHT_PC_W-1:0] target,
		input logic [5:0] btype, input logic z, input logic less);
		exe_nxt.valid  = 1'b1;
		exe_nxt.pc     = pc;
		exe_nxt.target = target;
		exe_nxt.btype  = btype;
		exe_nxt.z      = z;
		exe_nxt.less   = less;
	endtask

	task automatic drive_random();
		logic [31:0] kind;
		logic [31:0] bt;
		if_nxt.pc      = pool_pc();
		id_nxt.valid   = random_bit();
		id_nxt.pc      = pool_pc();
		id_nxt.target  = 10'(take_bits(10));
		kind           = take_bits(2);
		// kind 3 is a jump and kinds 1 and 2 are branches
		id_nxt.is_jump  = (kind == 3);
		id_nxt.is_btype = (kind == 1) || (kind == 2);
		exe_nxt.valid  = random_bit();
		exe_nxt.pc     = pool_pc();
		exe_nxt.target = 10'(take_bits(10));
		exe_nxt.z      = random_bit();
		exe_nxt.less   = random_bit();
		// codes 6 and 7 leave btype empty
		bt             = take_bits(3);
		exe_nxt.btype  = (bt < 6) ? (6'b1 << bt) : 6'b0;
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	task automatic reset_model();
		for (int s = 0; s < NSETS; s++)
		begin
			m_ptr[s] = '0;
			for (int w = 0; w < `BHT_WAYS; w++)
			begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_tgt[s][w]   = '0;
				m_cnt[s][w]   = '0;
			end
		end
	endtask

	function automatic void model_lookup(input pc_u pc, output logic hit, output int way);
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < `BHT_WAYS; w++)
		begin
			if (m_valid[pc.fld.set][w] && (m_tag[pc.fld.set][w] == pc.fld.tag))
			begin
				hit = 1'b1;
				way = w;
			end
		end
	endfunction

	// btype order beq bne blt bge bltu bgeu from the msb down
	function automatic logic branch_outcome(input exe_req_t r);
		case (r.btype)
			6'b100000: return r.z;
			6'b010000: return !r.z;
			6'b001000, 6'b000010: return r.less;
			6'b000100, 6'b000001: return !r.less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [`BHT_CNT_W-1:0] saturate(input logic [`BHT_CNT_W-1:0] cnt,
		input logic taken);
		if (taken)
			return (cnt == 2'b11) ? cnt : cnt + 2'b01;
		return (cnt == 2'b00) ? cnt : cnt - 2'b01;
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic fail_now();
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic string pred_text(input if_pred_t p);
		return $sformatf("hit=%0b taken=%0b pbt=%h", p.hit, p.taken, p.pbt);
	endfunction

	function automatic string res_text(input exe_res_t r);
		return $sformatf("corr=%b pbt=%h cni=%h", r.correction, r.pbt, r.cni);
	endfunction

	task automatic match_if_pred(input string name, input if_pred_t exp, input if_pred_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s if_pred expected %s actual %s", name,
				pred_text(exp), pred_text(act));
			fail_now();
		end
	endtask

	task automatic compare_exe_res(input string name, input exe_res_t exp, input exe_res_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s exe_res expected %s actual %s", name,
				res_text(exp), res_text(act));
			fail_now();
		end
	endtask

	task automatic verify_flush(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("MISMATCH %s flush expected %0b actual %0b", name, exp, act);
			fail_now();
		end
	endtask

	// drive at the falling edge and check mid low phase before stepping the model
	task automatic run_cycle(input string name);
		if_pred_t   exp_pred;
		exe_res_t   exp_res;
		logic       exp_flush;
		logic       if_hit;
		logic       id_hit;
		logic       exe_hit;
		logic       taken;
		logic       predicted;
		logic       is_branch;
		int         if_way;
		int         id_way;
		int         exe_way;
		logic [1:0] victim;
		logic [`BHT_SET_W-1:0] set_i;
		logic [`BHT_SET_W-1:0] set_e;
		logic [`BHT_SET_W-1:0] set_d;
		@(negedge CLK);
		if_req  = if_nxt;
		id_req  = id_nxt;
		exe_req = exe_nxt;
		#(HALF_PERIOD / 2);
		set_i = if_req.pc.fld.set;
		set_e = exe_req.pc.fld.set;
		set_d = id_req.pc.fld.set;
		// fetch target reads as zero on a miss
		model_lookup(if_req.pc, if_hit, if_way);
		exp_pred.hit   = if_hit;
		exp_pred.taken = if_hit && m_cnt[set_i][if_way][1];
		exp_pred.pbt   = if_hit ? m_tgt[set_i][if_way] : '0;
		// execute resolution
		model_lookup(exe_req.pc, exe_hit, exe_way);
		is_branch = exe_req.valid && (exe_req.btype != 6'b0);
		taken     = branch_outcome(exe_req);
		predicted = exe_hit && m_cnt[set_e][exe_way][1];
		if (!is_branch || (predicted == taken))
			exp_res.correction = NONE;
		else if (predicted)
			exp_res.correction = CNI;
		else
			exp_res.correction = PBT;
		exp_res.pbt = exe_req.target;
		exp_res.cni = exe_req.pc.raw + 10'd1;
		exp_flush   = (exp_res.correction != NONE);
		match_if_pred(name, exp_pred, if_pred);
		compare_exe_res(name, exp_res, exe_res);
		verify_flush(name, exp_flush, flush);
		// update first so an allocation into the same slot overwrites it
		if (is_branch && exe_hit)
			m_cnt[set_e][exe_way] = saturate(m_cnt[set_e][exe_way], taken);
		model_lookup(id_req.pc, id_hit, id_way);
		if (id_req.valid && (id_req.is_btype || id_req.is_jump) && !id_hit)
		begin
			victim                 = m_ptr[set_d];
			m_valid[set_d][victim] = 1'b1;
			m_tag[set_d][victim]   = id_req.pc.fld.tag;
			m_tgt[set_d][victim]   = id_req.target;
			m_cnt[set_d][victim]   = id_req.is_jump ? 2'b11 : 2'b01;
			m_ptr[set_d]           = m_ptr[set_d] + 2'd1;
		end
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		pc_u         br_pc;
		pc_u         jmp_pc;
		logic [31:0] r;
		int          wait_cnt;
		lfsr_q    = 32'h7fff_3696;
		if_req    = '0;
		id_req    = '0;
		exe_req   = '0;
		clear_requests();
		reset_model();
		br_pc  = pc_of(6'h05, 4'h1);
		jmp_pc = pc_of(6'h2c, 4'h2);
		wait_cnt = 0;
		while (!arst_n && (wait_cnt < RESET_TIMEOUT))
		begin
			@(posedge CLK);
			wait_cnt++;
		end
		if (!arst_n)
		begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			fail_now();
		end

		// every set misses in the empty table
		for (int s = 0; s < NSETS; s++)
		begin
			clear_requests();
			r = take_bits(6);
			if_nxt.pc = pc_of(r[5:0], 4'(s));
			run_cycle("reset_miss");
			match_if_pred("reset_miss", pred_value(1'b0, 1'b0, '0), if_pred);
			verify_flush("reset_miss", 1'b0, flush);
		end

		// branch enters weakly not taken and jump strongly taken
		clear_requests();
		decode_entry(br_pc, 10'h2a5, 1'b0);
		run_cycle("alloc_branch");
		clear_requests();
		if_nxt.pc = br_pc;
		decode_entry(jmp_pc, 10'h13b, 1'b1);
		run_cycle("alloc_jump");
		match_if_pred("branch_hit", pred_value(1'b1, 1'b0, 10'h2a5), if_pred);
		clear_requests();
		if_nxt.pc = jmp_pc;
		run_cycle("jump_lookup");
		match_if_pred("jump_hit", pred_value(1'b1, 1'b1, 10'h13b), if_pred);

		// five tags into set 5 push tag 1 out of way 0
		for (int t = 1; t <= 5; t++)
		begin
			clear_requests();
			decode_entry(pc_of(6'(t), 4'h5), 10'(t * 7), 1'b0);
			run_cycle("fill_set");
		end
		clear_requests();
		if_nxt.pc = pc_of(6'h01, 4'h5);
		run_cycle("evict_way0");
		match_if_pred("evict_way0", pred_value(1'b0, 1'b0, '0), if_pred);
		// tag 1 comes back into way 1 and replaces tag 2
		clear_requests();
		if_nxt.pc = pc_of(6'h02, 4'h5);
		decode_entry(pc_of(6'h01, 4'h5), 10'h007, 1'b0);
		run_cycle("refill_set");
		match_if_pred("tag2_present", pred_value(1'b1, 1'b0, 10'd14), if_pred);
		clear_requests();
		if_nxt.pc = pc_of(6'h02, 4'h5);
		run_cycle("evict_way1");
		match_if_pred("evict_way1", pred_value(1'b0, 1'b0, '0), if_pred);

		// train up to 11 where the first resolution redirects to the target
		for (int k = 0; k < 3; k++)
		begin
			clear_requests();
			resolve_branch(br_pc, 10'h2a5, 6'b100000, 1'b1, 1'b0);
			run_cycle("train_taken");
			if (k == 0)
				verify_flush("first_taken", 1'b1, flush);
		end
		clear_requests();
		if_nxt.pc = br_pc;
		run_cycle("strong_taken");
		match_if_pred("strong_taken", pred_value(1'b1, 1'b1, 10'h2a5), if_pred);
		// and back down to 00
		for (int k = 0; k < 4; k++)
		begin
			clear_requests();
			resolve_branch(br_pc, 10'h2a5, 6'b100000, 1'b0, 1'b0);
			run_cycle("train_not_taken");
		end
		clear_requests();
		if_nxt.pc = br_pc;
		run_cycle("strong_not_taken");
		match_if_pred("strong_not_taken", pred_value(1'b1, 1'b0, 10'h2a5), if_pred);

		// every branch type against every flag pair
		for (int bt = 0; bt < 6; bt++)
		begin
			for (int f = 0; f < 4; f++)
			begin
				clear_requests();
				resolve_branch(br_pc, 10'h2a5, 6'b1 << bt, f[1], f[0]);
				run_cycle("btype_sweep");
			end
		end

		// fill set 3 so the pointer is back at way 0
		for (int t = 0; t < 4; t++)
		begin
			clear_requests();
			decode_entry(pc_of(6'(16 + t), 4'h3), 10'(10'h300 + t), 1'b0);
			run_cycle("fill_set3");
		end
		// update of way 0 and allocation into way 0 together
		clear_requests();
		resolve_branch(pc_of(6'h10, 4'h3), 10'h300, 6'b100000, 1'b1, 1'b0);
		decode_entry(pc_of(6'h20, 4'h3), 10'h320, 1'b0);
		run_cycle("alloc_vs_update");
		clear_requests();
		if_nxt.pc = pc_of(6'h20, 4'h3);
		run_cycle("alloc_wins");
		match_if_pred("alloc_wins", pred_value(1'b1, 1'b0, 10'h320), if_pred);

		// all three stages at random
		for (int c = 0; c < RANDOM_CYCLES; c++)
		begin
			drive_random();
			run_cycle("random");
		end

		$display("STATUS: PASS");
		$finish;
	end

	// upper bound on the whole run
	initial
	begin
		#(2 * HALF_PERIOD * (RANDOM_CYCLES + 500));
		$display("simulation did not finish within its time limit");
		fail_now();
	end

endmodule

// ==== design/bht_top.sv ====
`timescale 1ns/1ns
`include "bht_config.svh"

module bht_top (
	input  logic              CLK,
	input  logic              arst_n,
	input  bht_pkg::if_req_t  if_req,
	input  bht_pkg::id_req_t  id_req,
	input  bht_pkg::exe_req_t exe_req,
	output bht_pkg::if_pred_t if_pred,
	output bht_pkg::exe_res_t exe_res,
	output logic              flush
);
	import bht_pkg::*;

	// write control to ways
	way_wr_t wr [`BHT_WAYS];

	// ways to selector
	way_hit_t   hit [`BHT_WAYS];
	bht_entry_t if_entry [`BHT_WAYS];
	bht_entry_t exe_entry [`BHT_WAYS];

	// selector back to write control
	logic                         id_hit;
	logic                         upd_en;
	logic [$clog2(`BHT_WAYS)-1:0] upd_way;
	logic [`BHT_CNT_W-1:0]        upd_cnt;
	logic [`BHT_SET_W-1:0]        exe_set;

	bht_write_ctl u_write_ctl (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.id_req  (id_req),
		.id_hit  (id_hit),
		.upd_en  (upd_en),
		.upd_way (upd_way),
		.upd_cnt (upd_cnt),
		.exe_set (exe_set),
		.wr      (wr)
	);

	// one instance per way, all look up in parallel
	for (genvar w = 0; w < `BHT_WAYS; w++)
	begin : g_way
		bht_way u_way (
			.CLK       (CLK),
			.arst_n    (arst_n),
			.if_pc     (if_req.pc),
			.id_pc     (id_req.pc),
			.exe_pc    (exe_req.pc),
			.wr        (wr[w]),
			.hit       (hit[w]),
			.if_entry  (if_entry[w]),
			.exe_entry (exe_entry[w])
		);
	end

	bht_select u_select (
		.if_pc     (if_req.pc),
		.exe_req   (exe_req),
		.hit       (hit),
		.if_entry  (if_entry),
		.exe_entry (exe_entry),
		.if_pred   (if_pred),
		.exe_res   (exe_res),
		.flush     (flush),
		.id_hit    (id_hit),
		.upd_en    (upd_en),
		.upd_way   (upd_way),
		.upd_cnt   (upd_cnt),
		.exe_set   (exe_set)
	);

endmodule

// ==== bht/bht_select.sv ====
`timescale 1ns/1ns
`include "bht_config.svh"

module bht_select (
	input  bht_pkg::pc_u                  if_pc,
	input  bht_pkg::exe_req_t             exe_req,
	input  bht_pkg::way_hit_t             hit [`BHT_WAYS],
	input  bht_pkg::bht_entry_t           if_entry [`BHT_WAYS],
	input  bht_pkg::bht_entry_t           exe_entry [`BHT_WAYS],
	output bht_pkg::if_pred_t             if_pred,
	output bht_pkg::exe_res_t             exe_res,
	output logic                          flush,
	output logic                          id_hit,
	output logic                          upd_en,
	output logic [$clog2(`BHT_WAYS)-1:0]  upd_way,
	output logic [`BHT_CNT_W-1:0]         upd_cnt,
	output logic [`BHT_SET_W-1:0]         exe_set
);
	import bht_pkg::*;

	localparam int WAY_W = $clog2(`BHT_WAYS);

	logic [`BHT_WAYS-1:0]  if_hits;
	logic [`BHT_WAYS-1:0]  id_hits;
	logic [`BHT_WAYS-1:0]  exe_hits;
	bht_entry_t            if_sel;
	bht_entry_t            exe_sel;
	logic [`BHT_CNT_W-1:0] exe_cnt;
	logic                  exe_hit;
	logic                  is_branch;
	logic                  outcome;
	logic                  predicted;

	////////////////////////////////////////
	// hit muxing
	////////////////////////////////////////

	// hits are one-hot, so an and-or mux is enough
	always_comb
	begin
		if_sel  = '0;
		exe_sel = '0;
		exe_cnt = '0;
		upd_way = '0;
		for (int w = 0; w < `BHT_WAYS; w++)
		begin
			if_hits[w]  = hit[w].if_hit;
			id_hits[w]  = hit[w].id_hit;
			exe_hits[w] = hit[w].exe_hit;
			if (hit[w].if_hit)
			begin
				if_sel = if_sel | if_entry[w];
			end
			if (hit[w].exe_hit)
			begin
				exe_sel = exe_sel | exe_entry[w];
				exe_cnt = exe_cnt | hit[w].exe_cnt;
				upd_way = upd_way | WAY_W'(w);
			end
		end
	end

	// fetch prediction, not taken on a miss
	assign if_pred.hit   = |if_hits;
	assign if_pred.taken = if_pred.hit && if_sel.cnt[`BHT_CNT_W-1];
	assign if_pred.pbt   = if_sel.target;

	// decode only needs to know whether to allocate
	assign id_hit = |id_hits;

	////////////////////////////////////////
	// execute resolution
	////////////////////////////////////////

	assign exe_hit   = |exe_hits;
	assign is_branch = exe_req.valid && (|exe_req.btype);
	assign exe_set   = exe_req.pc.fld.set;

	// unsigned and signed compares share the less flag
	assign outcome =
		(exe_req.btype[BT_BEQ] && exe_req.z) ||
		(exe_req.btype[BT_BNE] && !exe_req.z) ||
		((exe_req.btype[BT_BLT] || exe_req.btype[BT_BLTU]) && exe_req.less) ||
		((exe_req.btype[BT_BGE] || exe_req.btype[BT_BGEU]) && !exe_req.less);

	// what fetch saw, a miss predicts not taken
	assign predicted = exe_hit && exe_sel.cnt[`BHT_CNT_W-1];

	// saturating counter step
	always_comb
	begin
		upd_cnt = exe_cnt;
		if (outcome && (exe_cnt != '1))
		begin
			upd_cnt = exe_cnt + 1'b1;
		end
		else if (!outcome && (exe_cnt != '0))
		begin
			upd_cnt = exe_cnt - 1'b1;
		end
	end

	// only resolved branches that are in the table train it
	assign upd_en = is_branch && exe_hit;

	always_comb
	begin
		exe_res.correction = NONE;
		if (is_branch && (predicted != outcome))
		begin
			// taken but predicted not taken, redirect to target
			exe_res.correction = outcome ? PBT : CNI;
		end
	end

	assign exe_res.pbt = exe_req.target;
	// next sequential word, wraps at pc width
	assign exe_res.cni = exe_req.pc.raw + 1'b1;

	assign flush = exe_res.correction[1];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// no duplicate tags across ways, so each port hits at most one way
	always_comb
	begin
		a_hit_onehot: assert final ($onehot0(if_hits) && $onehot0(id_hits)
			&& $onehot0(exe_hits));
		a_btype_onehot: assert final (!exe_req.valid || $onehot0(exe_req.btype));
		// the selected fetch entry really carries the fetch tag
		a_if_tag: assert final (!if_pred.hit || (if_sel.tag == if_pc.fld.tag));
	end

endmodule

// ==== bht/bht_write_ctl.sv ====
`timescale 1ns/1ns
`include "bht_config.svh"

module bht_write_ctl (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  bht_pkg::id_req_t              id_req,
	input  logic                          id_hit,
	input  logic                          upd_en,
	input  logic [$clog2(`BHT_WAYS)-1:0]  upd_way,
	input  logic [`BHT_CNT_W-1:0]         upd_cnt,
	input  logic [`BHT_SET_W-1:0]         exe_set,
	output bht_pkg::way_wr_t              wr [`BHT_WAYS]
);
	import bht_pkg::*;

	localparam int NSETS = 1 << `BHT_SET_W;
	localparam int WAY_W = $clog2(`BHT_WAYS);

	// initial counters, weakly not taken and strongly taken
	localparam logic [`BHT_CNT_W-1:0] CNT_BRANCH = 2'b01;
	localparam logic [`BHT_CNT_W-1:0] CNT_JUMP   = 2'b11;

	////////////////////////////////////////
	// allocation request
	////////////////////////////////////////

	logic                  alloc_req;
	logic [`BHT_SET_W-1:0] id_set;
	logic [WAY_W-1:0]      victim;
	bht_entry_t            new_entry;

	// fifo replacement pointer per set
	logic [WAY_W-1:0] fifo_ptr_q [NSETS];

	assign id_set = id_req.pc.fld.set;

	// only a control-flow instruction missing in every way
	assign alloc_req = id_req.valid && (id_req.is_btype || id_req.is_jump) && !id_hit;

	assign victim = fifo_ptr_q[id_set];

	// jumps enter strongly taken and are never resolved here
	assign new_entry = '{
		valid:  1'b1,
		tag:    id_req.pc.fld.tag,
		target: id_req.target,
		cnt:    id_req.is_jump ? CNT_JUMP : CNT_BRANCH
	};

	////////////////////////////////////////
	// replacement pointers
	////////////////////////////////////////

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < NSETS; s++)
			begin
				fifo_ptr_q[s] <= '0;
			end
		end
		else if (alloc_req)
		begin
			// wraps modulo the way count
			fifo_ptr_q[id_set] <= victim + 1'b1;
		end
	end

	////////////////////////////////////////
	// per-way write steering
	////////////////////////////////////////

	always_comb
	begin
		for (int w = 0; w < `BHT_WAYS; w++)
		begin
			// allocation goes to the pointed way only
			wr[w].alloc_en    = alloc_req && (victim == WAY_W'(w));
			wr[w].alloc_set   = id_set;
			wr[w].alloc_entry = new_entry;
			// update goes to the way that hit in execute
			wr[w].upd_en      = upd_en && (upd_way == WAY_W'(w));
			wr[w].upd_set     = exe_set;
			wr[w].upd_cnt     = upd_cnt;
		end
	end

	// decode never flags an instruction as both branch and jump
	a_alloc_kind: assert property (@(posedge CLK) disable iff (!arst_n)
		alloc_req |-> (id_req.is_btype ^ id_req.is_jump));

endmodule

// ==== bht/bht_way.sv ====
`timescale 1ns/1ns
`include "bht_config.svh"

module bht_way (
	input  logic                CLK,
	input  logic                arst_n,
	input  bht_pkg::pc_u        if_pc,
	input  bht_pkg::pc_u        id_pc,
	input  bht_pkg::pc_u        exe_pc,
	input  bht_pkg::way_wr_t    wr,
	output bht_pkg::way_hit_t   hit,
	output bht_pkg::bht_entry_t if_entry,
	output bht_pkg::bht_entry_t exe_entry
);
	import bht_pkg::*;

	localparam int NSETS = 1 << `BHT_SET_W;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// one valid bit and one entry per set
	logic [NSETS-1:0]      valid_q;
	logic [`BHT_TAG_W-1:0] tag_q [NSETS];
	logic [`BHT_PC_W-1:0]  tgt_q [NSETS];
	logic [`BHT_CNT_W-1:0] cnt_q [NSETS];

	bht_entry_t id_entry;
	logic       upd_ok;

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////

	// fetch port also sends out the entry for its target
	assign if_entry = '{
		valid:  valid_q[if_pc.fld.set],
		tag:    tag_q[if_pc.fld.set],
		target: tgt_q[if_pc.fld.set],
		cnt:    cnt_q[if_pc.fld.set]
	};

	// decode port only feeds the hit
	assign id_entry = '{
		valid:  valid_q[id_pc.fld.set],
		tag:    tag_q[id_pc.fld.set],
		target: tgt_q[id_pc.fld.set],
		cnt:    cnt_q[id_pc.fld.set]
	};

	// execute port counter feeds the update
	assign exe_entry = '{
		valid:  valid_q[exe_pc.fld.set],
		tag:    tag_q[exe_pc.fld.set],
		target: tgt_q[exe_pc.fld.set],
		cnt:    cnt_q[exe_pc.fld.set]
	};

	// a hit needs a valid entry with matching tag
	assign hit.if_hit  = if_entry.valid && (if_entry.tag == if_pc.fld.tag);
	assign hit.id_hit  = id_entry.valid && (id_entry.tag == id_pc.fld.tag);
	assign hit.exe_hit = exe_entry.valid && (exe_entry.tag == exe_pc.fld.tag);
	assign hit.exe_cnt = exe_entry.cnt;

	////////////////////////////////////////
	// write ports
	////////////////////////////////////////

	// allocation in the same set overrides the counter update
	assign upd_ok = wr.upd_en && !(wr.alloc_en && (wr.alloc_set == wr.upd_set));

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
		end
		else if (wr.alloc_en)
		begin
			valid_q[wr.alloc_set] <= 1'b1;
		end
	end

	always_ff @(posedge CLK)
	begin
		// whole entry on allocation
		if (wr.alloc_en)
		begin
			tag_q[wr.alloc_set] <= wr.alloc_entry.tag;
			tgt_q[wr.alloc_set] <= wr.alloc_entry.target;
			cnt_q[wr.alloc_set] <= wr.alloc_entry.cnt;
		end
		// counter only on update
		if (upd_ok)
		begin
			cnt_q[wr.upd_set] <= wr.upd_cnt;
		end
	end

	// allocation writes the decode pc's tag into its set and only while this way misses it
	a_alloc_fresh: assert property (@(posedge CLK) disable iff (!arst_n)
		wr.alloc_en |-> (wr.alloc_set == id_pc.fld.set)
			&& (wr.alloc_entry.tag == id_pc.fld.tag) && !hit.id_hit);

endmodule

// ==== common/bht_pkg.sv ====
`include "bht_config.svh"

package bht_pkg;

	// pc split into tag (upper) and set index (lower)
	typedef struct packed {
		logic [`BHT_TAG_W-1:0] tag;
		logic [`BHT_SET_W-1:0] set;
	} pc_fld_t;

	// same pc word, read raw or as tag/set
	typedef union packed {
		logic [`BHT_PC_W-1:0] raw;
		pc_fld_t              fld;
	} pc_u;

	// one table entry
	typedef struct packed {
		logic                  valid;
		logic [`BHT_TAG_W-1:0] tag;
		logic [`BHT_PC_W-1:0]  target;
		logic [`BHT_CNT_W-1:0] cnt;
	} bht_entry_t;

	// next-pc correction code, msb doubles as flush
	typedef enum logic [1:0] {
		NONE = 2'b00,
		CNI  = 2'b10,
		PBT  = 2'b11
	} corr_e;

	// btype one-hot bit positions
	localparam int BT_BEQ  = 5;
	localparam int BT_BNE  = 4;
	localparam int BT_BLT  = 3;
	localparam int BT_BGE  = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	typedef struct packed {
		pc_u pc;
	} if_req_t;

	typedef struct packed {
		logic                 valid;
		pc_u                  pc;
		logic [`BHT_PC_W-1:0] target;
		logic                 is_jump;
		logic                 is_btype;
	} id_req_t;

	typedef struct packed {
		logic                 valid;
		pc_u                  pc;
		logic [`BHT_PC_W-1:0] target;
		logic                 z;
		logic                 less;
		logic [5:0]           btype;
	} exe_req_t;

	typedef struct packed {
		logic                 hit;
		logic                 taken;
		logic [`BHT_PC_W-1:0] pbt;
	} if_pred_t;

	typedef struct packed {
		corr_e                correction;
		logic [`BHT_PC_W-1:0] pbt;
		logic [`BHT_PC_W-1:0] cni;
	} exe_res_t;

	// per-way tag compare results
	typedef struct packed {
		logic                  if_hit;
		logic                  id_hit;
		logic                  exe_hit;
		logic [`BHT_CNT_W-1:0] exe_cnt;
	} way_hit_t;

	// per-way write request, allocation and counter update
	typedef struct packed {
		logic                  alloc_en;
		logic [`BHT_SET_W-1:0] alloc_set;
		bht_entry_t            alloc_entry;
		logic                  upd_en;
		logic [`BHT_SET_W-1:0] upd_set;
		logic [`BHT_CNT_W-1:0] upd_cnt;
	} way_wr_t;

endpackage

// ==== common/bht_config.svh ====
`ifndef BHT_CONFIG_SVH
`define BHT_CONFIG_SVH

////////////////////////////////////////
// table geometry
////////////////////////////////////////

// word-addressed pc, split as {tag, set}
`define BHT_PC_W  10
`define BHT_SET_W 4
`define BHT_TAG_W 6

// associativity, ways per set
`define BHT_WAYS  4

// 2-bit saturating counter, high bit is the prediction
`define BHT_CNT_W 2

`endif
